// ==== src/bus_arbiter.sv ====
/* Bus arbiter: fixed-priority grant, lowest master index wins.
   Switches the granted master's frame to all slaves and routes replies back. */
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                                clk,
    input  logic                                rst,
    master_link_if.arbiter                      mst [bus_cfg_pkg::NUM_MASTERS],
    slave_link_if.arbiter                       slv [bus_cfg_pkg::NUM_SLAVES],
    output logic [bus_cfg_pkg::NUM_MASTERS-1:0] requests,
    output logic                                utilization,
    output logic                                bus
);

    import bus_cfg_pkg::*;

    logic [NUM_MASTERS-1:0] req_vec;
    logic [NUM_MASTERS-1:0] gnt_q;
    logic [NUM_MASTERS-1:0] lowest;
    logic [NUM_MASTERS-1:0] m2s_bit_vec;
    logic [NUM_MASTERS-1:0] m2s_valid_vec;
    logic [NUM_SLAVES-1:0]  s2m_bit_vec;
    logic [NUM_SLAVES-1:0]  s2m_valid_vec;
    logic                   sel_bit;
    logic                   sel_valid;
    logic                   rsp_bit;
    logic                   rsp_valid;

    // gather master lanes, return grant and reply
    for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_mst
        assign req_vec[i]       = mst[i].req;
        assign m2s_bit_vec[i]   = mst[i].m2s_bit;
        assign m2s_valid_vec[i] = mst[i].m2s_valid;
        assign mst[i].gnt       = gnt_q[i];
        assign mst[i].s2m_bit   = gnt_q[i] & rsp_bit;
        assign mst[i].s2m_valid = gnt_q[i] & rsp_valid;
    end

    // broadcast to slaves, replies only count while that slave is busy
    for (genvar k = 0; k < NUM_SLAVES; k++) begin : g_slv
        assign slv[k].m2s_bit   = sel_bit;
        assign slv[k].m2s_valid = sel_valid;
        assign s2m_bit_vec[k]   = slv[k].s2m_bit & slv[k].busy;
        assign s2m_valid_vec[k] = slv[k].s2m_valid & slv[k].busy;
    end

    // lowest set request bit
    assign lowest = req_vec & (~req_vec + 1'b1);

    // one-hot grant, held until the owner drops req
    always_ff @(posedge clk) begin
        if (rst) begin
            gnt_q <= '0;
        end else if (gnt_q == '0) begin
            gnt_q <= lowest;
        end else if ((gnt_q & req_vec) == '0) begin
            gnt_q <= '0;
        end
    end

    assign sel_bit   = |(gnt_q & m2s_bit_vec);
    assign sel_valid = |(gnt_q & m2s_valid_vec);
    assign rsp_bit   = |s2m_bit_vec;
    assign rsp_valid = |s2m_valid_vec;

    assign requests    = req_vec;
    assign utilization = |gnt_q;
    // request lane as seen on the bus
    assign bus         = sel_bit;

endmodule

// ==== src/bus_cfg_pkg.sv ====
/* Shared serial bus configuration.
   Word and address sizes, bus population, slave ids and timing constants. */
package bus_cfg_pkg;

    // data word and address layout
    localparam int DATA_WIDTH     = 8;
    localparam int ADDRS_WIDTH    = 15;
    // address = {slave id, offset}
    localparam int SLAVE_ID_WIDTH = 3;
    localparam int OFFSET_WIDTH   = 12;

    // bus population
    localparam int NUM_MASTERS    = 3;
    localparam int NUM_SLAVES     = 3;
    // slave k answers id FIRST_SLAVE_ID + k
    localparam int FIRST_SLAVE_ID = 1;

    // words per memory slave, offset wraps modulo this
    localparam int MEM_DEPTH      = 16;

    // read timeout counter width, 2**6 = 64 cycles
    localparam int TIMEOUT_LEN    = 6;
    // cycles from end of a read frame to first reply bit
    // counted from the frame_valid cycle, must be 2 or more
    localparam int REPLY_GAP      = 2;

endpackage

// ==== src/bus_frame_pkg.sv ====
/* Shared serial bus frame definitions.
   Data word, address and the request frame carried on the bus. */
package bus_frame_pkg;

    import bus_cfg_pkg::*;

    // one stored word
    typedef logic [DATA_WIDTH-1:0] data_t;

    // {slave id, offset}
    typedef logic [ADDRS_WIDTH-1:0] addr_t;

    // request frame
    // shifted out LSB first, so wdata leads and rw trails
    typedef struct packed {
        logic  rw;      // 1 = read, 0 = write
        addr_t addr;
        data_t wdata;   // don't care on reads
    } request_t;

    // bits per request frame on the wire
    localparam int FRAME_BITS = $bits(request_t);

endpackage

// ==== src/bus_master.sv ====
/* Bus master: one read or write per execute pulse.
   Requests the bus, sends the frame, waits for a reply or times out. */
`timescale 1ns/1ps

module bus_master (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 execute,
    input  logic                 rw,
    input  bus_frame_pkg::addr_t address,
    input  bus_frame_pkg::data_t wdata,
    master_link_if.master        link,
    output bus_frame_pkg::data_t rdata,
    output logic                 dvalid,
    output logic                 error,
    output logic                 busy
);

    import bus_cfg_pkg::*;
    import bus_frame_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_SEND,
        ST_WAIT
    } state_t;

    state_t                 state;
    request_t               req_q;
    logic [TIMEOUT_LEN-1:0] timer;
    logic                   tx_start;
    logic                   tx_done;
    logic                   rx_valid;
    logic                   timed_out;
    data_t                  rx_data;

    // request frame out
    serial_tx #(.payload_t(request_t)) u_tx (
        .clk       (clk),
        .rst       (rst),
        .start     (tx_start),
        .payload   (req_q),
        .bit_out   (link.m2s_bit),
        .bit_valid (link.m2s_valid),
        .done      (tx_done)
    );

    // read reply in
    serial_rx #(.payload_t(data_t)) u_rx (
        .clk         (clk),
        .rst         (rst),
        .bit_in      (link.s2m_bit),
        .bit_valid   (link.s2m_valid),
        .payload     (rx_data),
        .frame_valid (rx_valid)
    );

    // operands latched at execute
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && execute) begin
            req_q.rw    <= rw;
            req_q.addr  <= address;
            req_q.wdata <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            timer <= '0;
        end else begin
            case (state)
                // execute while busy never reaches here
                ST_IDLE: if (execute) state <= ST_REQ;
                ST_REQ:  if (link.gnt) state <= ST_SEND;
                ST_SEND: begin
                    if (tx_done) begin
                        state <= req_q.rw ? ST_WAIT : ST_IDLE;
                        timer <= '0;
                    end
                end
                ST_WAIT: begin
                    // any reply bit restarts the timeout
                    if (rx_valid || timed_out) begin
                        state <= ST_IDLE;
                    end else if (link.s2m_valid) begin
                        timer <= '0;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // frame starts the cycle after grant is seen
    assign tx_start  = (state == ST_REQ) && link.gnt;
    assign timed_out = &timer;

    assign busy     = (state != ST_IDLE);
    assign link.req = busy;
    assign dvalid   = (state == ST_WAIT) && (rx_valid || timed_out);
    assign error    = (state == ST_WAIT) && timed_out && !rx_valid;
    assign rdata    = rx_data;

endmodule

// ==== src/bus_top.sv ====
/* Shared serial bus top: three masters, arbiter and three memory slaves,
   with per-master and per-slave signals as plain packed vectors. */
`timescale 1ns/1ps

module bus_top (
    input  logic                                                 in_clk,
    input  logic                                                 rst,
    input  logic [bus_cfg_pkg::NUM_MASTERS-1:0]                  m_execute,
    input  logic [bus_cfg_pkg::NUM_MASTERS-1:0]                  m_rw,
    input  bus_frame_pkg::addr_t [bus_cfg_pkg::NUM_MASTERS-1:0]  m_address,
    input  bus_frame_pkg::data_t [bus_cfg_pkg::NUM_MASTERS-1:0]  m_wdata,
    output bus_frame_pkg::data_t [bus_cfg_pkg::NUM_MASTERS-1:0]  m_rdata,
    output logic [bus_cfg_pkg::NUM_MASTERS-1:0]                  m_dvalid,
    output logic [bus_cfg_pkg::NUM_MASTERS-1:0]                  m_error,
    output logic [bus_cfg_pkg::NUM_MASTERS-1:0]                  m_busy,
    output logic [bus_cfg_pkg::NUM_MASTERS-1:0]                  requests,
    output logic                                                 utilization,
    output logic [bus_cfg_pkg::NUM_SLAVES-1:0]                   slave_busy,
    output logic                                                 bus
);

    import bus_cfg_pkg::*;

    // point-to-point links through the arbiter
    master_link_if mst_link [NUM_MASTERS] ();
    slave_link_if  slv_link [NUM_SLAVES] ();

    bus_arbiter u_arbiter (
        .clk         (in_clk),
        .rst         (rst),
        .mst         (mst_link),
        .slv         (slv_link),
        .requests    (requests),
        .utilization (utilization),
        .bus         (bus)
    );

    // master 0 has highest priority
    for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_master
        bus_master u_master (
            .clk     (in_clk),
            .rst     (rst),
            .execute (m_execute[i]),
            .rw      (m_rw[i]),
            .address (m_address[i]),
            .wdata   (m_wdata[i]),
            .link    (mst_link[i]),
            .rdata   (m_rdata[i]),
            .dvalid  (m_dvalid[i]),
            .error   (m_error[i]),
            .busy    (m_busy[i])
        );
    end

    // ids 1..3, other ids go unanswered
    for (genvar k = 0; k < NUM_SLAVES; k++) begin : g_slave
        memory_slave #(
            .SLAVE_ID (SLAVE_ID_WIDTH'(FIRST_SLAVE_ID + k))
        ) u_slave (
            .clk  (in_clk),
            .rst  (rst),
            .link (slv_link[k]),
            .busy (slave_busy[k])
        );
    end

endmodule

// ==== src/master_link_if.sv ====
/* Master link: request/grant handshake and serial lanes
   between one bus master and the arbiter. */
`timescale 1ns/1ps

interface master_link_if;

    // request held high until the transaction ends
    logic req;
    logic gnt;

    // request frame toward the slaves
    logic m2s_bit;
    logic m2s_valid;

    // reply, only routed while granted
    logic s2m_bit;
    logic s2m_valid;

    modport master (
        output req, m2s_bit, m2s_valid,
        input  gnt, s2m_bit, s2m_valid
    );

    modport arbiter (
        input  req, m2s_bit, m2s_valid,
        output gnt, s2m_bit, s2m_valid
    );

endinterface

// ==== src/memory_slave.sv ====
/* Memory slave: decodes its id from each frame, stores writes
   and answers reads with one word after a fixed gap. */
`timescale 1ns/1ps

module memory_slave #(
    parameter logic [bus_cfg_pkg::SLAVE_ID_WIDTH-1:0] SLAVE_ID = 1
) (
    input  logic        clk,
    input  logic        rst,
    slave_link_if.slave link,
    output logic        busy
);

    import bus_cfg_pkg::*;
    import bus_frame_pkg::*;

    request_t                       frame;
    logic                           frame_valid;
    logic                           hit;
    logic [OFFSET_WIDTH-1:0]        offset;
    logic [$clog2(MEM_DEPTH)-1:0]   index;
    data_t                          mem [MEM_DEPTH];
    data_t                          rdata_q;
    logic                           busy_q;
    logic                           gap_wait;
    logic [$clog2(REPLY_GAP+1)-1:0] gap_cnt;
    logic                           tx_start;
    logic                           tx_done;

    // every slave hears every frame
    serial_rx #(.payload_t(request_t)) u_rx (
        .clk         (clk),
        .rst         (rst),
        .bit_in      (link.m2s_bit),
        .bit_valid   (link.m2s_valid),
        .payload     (frame),
        .frame_valid (frame_valid)
    );

    serial_tx #(.payload_t(data_t)) u_tx (
        .clk       (clk),
        .rst       (rst),
        .start     (tx_start),
        .payload   (rdata_q),
        .bit_out   (link.s2m_bit),
        .bit_valid (link.s2m_valid),
        .done      (tx_done)
    );

    // offset wraps modulo MEM_DEPTH
    assign offset = frame.addr[OFFSET_WIDTH-1:0];
    assign index  = offset[$clog2(MEM_DEPTH)-1:0];
    assign hit    = frame_valid && (frame.addr[ADDRS_WIDTH-1 -: SLAVE_ID_WIDTH] == SLAVE_ID);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (hit && !frame.rw) begin
            mem[index] <= frame.wdata;
        end
    end

    // read word, ready before the reply starts
    always_ff @(posedge clk) begin
        if (hit && frame.rw) begin
            rdata_q <= mem[index];
        end
    end

    // gap counter covers the start cycle too
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q   <= 1'b0;
            gap_wait <= 1'b0;
            gap_cnt  <= '0;
        end else begin
            if (hit && frame.rw) begin
                busy_q   <= 1'b1;
                gap_wait <= 1'b1;
                gap_cnt  <= $bits(gap_cnt)'(REPLY_GAP - 2);
            end else if (gap_wait) begin
                if (gap_cnt == '0) begin
                    gap_wait <= 1'b0;
                end else begin
                    gap_cnt <= gap_cnt - 1'b1;
                end
            end
            // last reply bit ends the read
            if (tx_done) begin
                busy_q <= 1'b0;
            end
        end
    end

    assign tx_start  = gap_wait && (gap_cnt == '0);
    // one cycle for a write, through the reply for a read
    assign busy      = hit || busy_q;
    assign link.busy = busy;

endmodule

// ==== src/serial_rx.sv ====
/* Serial receiver: assembles a payload from LSB-first bits
   and flags the cycle after the last bit. */
`timescale 1ns/1ps

module serial_rx #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     bit_in,
    input  logic     bit_valid,
    output payload_t payload,
    output logic     frame_valid
);

    logic [$bits(payload_t)-1:0]         shift;
    // bits collected so far in this frame
    logic [$clog2($bits(payload_t))-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            shift       <= '0;
            count       <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            if (bit_valid) begin
                // new bit enters at the top, first bit ends at bit 0
                shift <= {bit_in, shift[$bits(payload_t)-1:1]};
                if (count == $bits(count)'($bits(payload_t) - 1)) begin
                    count       <= '0;
                    frame_valid <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    // held until the next frame starts shifting in
    assign payload = payload_t'(shift);

endmodule

// ==== src/serial_tx.sv ====
/* Serial transmitter: shifts a payload out LSB first,
   one bit per cycle with a valid strobe and a done pulse. */
`timescale 1ns/1ps

module serial_tx #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  payload_t payload,
    output logic     bit_out,
    output logic     bit_valid,
    output logic     done
);

    logic [$bits(payload_t)-1:0]         frame;
    logic [$bits(payload_t)-1:0]         shift;
    // bits left after the one on the wire
    logic [$clog2($bits(payload_t))-1:0] remain;

    assign frame = payload;

    // control and line, start ignored mid-frame
    always_ff @(posedge clk) begin
        if (rst) begin
            bit_out   <= 1'b0;
            bit_valid <= 1'b0;
            remain    <= '0;
        end else if (start && !bit_valid) begin
            bit_out   <= frame[0];
            bit_valid <= 1'b1;
            remain    <= $bits(remain)'($bits(payload_t) - 1);
        end else if (bit_valid) begin
            if (remain == '0) begin
                // line idles low
                bit_out   <= 1'b0;
                bit_valid <= 1'b0;
            end else begin
                bit_out <= shift[0];
                remain  <= remain - 1'b1;
            end
        end
    end

    // bits still to go
    always_ff @(posedge clk) begin
        if (start && !bit_valid) begin
            shift <= frame >> 1;
        end else if (bit_valid) begin
            shift <= shift >> 1;
        end
    end

    // with the last bit
    assign done = bit_valid && (remain == '0);

endmodule

// ==== src/slave_link_if.sv ====
/* Slave link: broadcast request lane, reply lane and busy flag
   between the arbiter and one memory slave. */
`timescale 1ns/1ps

interface slave_link_if;

    // granted master's frame, same on every slave
    logic m2s_bit;
    logic m2s_valid;

    // reply, only the addressed slave drives valid
    logic s2m_bit;
    logic s2m_valid;

    // slave is handling a frame
    logic busy;

    modport slave (
        input  m2s_bit, m2s_valid,
        output s2m_bit, s2m_valid, busy
    );

    modport arbiter (
        output m2s_bit, m2s_valid,
        input  s2m_bit, s2m_valid, busy
    );

endinterface

// ==== tb/bus_top_props.sv ====
/* Bus protocol checks, bound into the bus top level.
   Grant, slave select, completion and reset behavior. */
`timescale 1ns/1ps

module bus_top_props (
    input logic                                in_clk,
    input logic                                rst,
    input logic [bus_cfg_pkg::NUM_MASTERS-1:0] m_dvalid,
    input logic [bus_cfg_pkg::NUM_MASTERS-1:0] m_error,
    input logic [bus_cfg_pkg::NUM_MASTERS-1:0] m_busy,
    input logic [bus_cfg_pkg::NUM_MASTERS-1:0] requests,
    input logic                                utilization,
    input logic [bus_cfg_pkg::NUM_SLAVES-1:0]  slave_busy,
    input logic                                bus
);

    import bus_cfg_pkg::*;

    // set by any failing property
    logic check_failed = 1'b0;

    // grant needs a live request, or the release cycle right after it
    a_grant_has_req: assert property (@(posedge in_clk) disable iff (rst)
        utilization |-> (|requests) || $past(|requests))
        else begin
            $error("bus granted with no request pending");
            check_failed = 1'b1;
        end

    // only the addressed slave is busy
    a_one_slave: assert property (@(posedge in_clk) disable iff (rst)
        $onehot0(slave_busy))
        else begin
            $error("more than one slave busy");
            check_failed = 1'b1;
        end

    a_dvalid_in_busy: assert property (@(posedge in_clk) disable iff (rst)
        (m_dvalid & ~m_busy) == '0)
        else begin
            $error("m_dvalid outside m_busy");
            check_failed = 1'b1;
        end

    // second reset cycle on, registers already cleared
    a_reset_quiet: assert property (@(posedge in_clk)
        rst && $past(rst) |-> (m_busy == '0) && (m_dvalid == '0) && (m_error == '0)
            && (requests == '0) && !utilization && (slave_busy == '0) && !bus)
        else begin
            $error("outputs not cleared during reset");
            check_failed = 1'b1;
        end

    // worst case is a timed-out read or the last of three queued writes
    for (genvar i = 0; i < NUM_MASTERS; i++) begin : g_busy
        a_busy_ends: assert property (@(posedge in_clk) disable iff (rst)
            $rose(m_busy[i]) |-> ##[1:110] !m_busy[i])
            else begin
                $error("m_busy held past 110 cycles");
                check_failed = 1'b1;
            end
    end

endmodule

bind bus_top bus_top_props props0 (.*);

// ==== tb/bus_top_tb.sv ====
/* Testbench for the shared serial bus.
   Drives the three masters, keeps a memory model and checks every read. */
`timescale 1ns/1ps

module bus_top_tb;

    import bus_cfg_pkg::*;
    import bus_frame_pkg::*;

    logic                    in_clk;
    logic                    rst;
    logic [NUM_MASTERS-1:0]  m_execute;
    logic [NUM_MASTERS-1:0]  m_rw;
    addr_t [NUM_MASTERS-1:0] m_address;
    data_t [NUM_MASTERS-1:0] m_wdata;
    data_t [NUM_MASTERS-1:0] m_rdata;
    logic [NUM_MASTERS-1:0]  m_dvalid;
    logic [NUM_MASTERS-1:0]  m_error;
    logic [NUM_MASTERS-1:0]  m_busy;
    logic [NUM_MASTERS-1:0]  requests;
    logic                    utilization;
    logic [NUM_SLAVES-1:0]   slave_busy;
    logic                    bus;
    // expected words, key is id * MEM_DEPTH + offset mod MEM_DEPTH
    data_t                   model [int];
    int                      cycles = 0;

    bus_top dut0 (.*);

    // 40 ns period
    always #20 in_clk = ~in_clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "%s", why);
    endtask

    task automatic report_mismatch(input string test, input int expected, input int actual);
        abort_run($sformatf("FAILED %s expected %0h actual %0h", test, expected, actual));
    endtask

    // about 32 transactions of at most 110 cycles, with margin
    always @(posedge in_clk) begin
        cycles = cycles + 1;
        if (cycles >= 4000) begin
            abort_run("run passed 4000 cycles without finishing");
        end
    end

    always @(negedge in_clk) begin
        if (dut0.props0.check_failed) begin
            abort_run("a bus property assertion failed");
        end
    end

    function automatic addr_t make_addr(input int id, input int offset);
        return {id[SLAVE_ID_WIDTH-1:0], offset[OFFSET_WIDTH-1:0]};
    endfunction

    function automatic int model_key(input addr_t addr);
        return int'(addr[ADDRS_WIDTH-1 -: SLAVE_ID_WIDTH]) * MEM_DEPTH
            + int'(addr[OFFSET_WIDTH-1:0]) % MEM_DEPTH;
    endfunction

    // memories come out of reset as zero
    function automatic data_t model_read(input addr_t addr);
        if (model.exists(model_key(addr))) begin
            return model[model_key(addr)];
        end
        return '0;
    endfunction

    // one transaction on master m, returns when m_busy falls
    task automatic run_op(input int m, input logic rw, input addr_t addr, input data_t wd,
                          output data_t rd, output logic err, output logic touched);
        int   k;
        logic seen;
        @(posedge in_clk);
        m_rw[m]      <= rw;
        m_address[m] <= addr;
        m_wdata[m]   <= wd;
        m_execute[m] <= 1'b1;
        @(posedge in_clk);
        m_execute[m] <= 1'b0;
        rd      = '0;
        err     = 1'b0;
        seen    = 1'b0;
        touched = 1'b0;
        k       = 0;
        @(negedge in_clk);
        while (m_busy[m]) begin
            // grant lands one cycle after req
            if (k > 0) begin
                assert (utilization) else abort_run("utilization low while a master owns the bus");
            end
            if (m_dvalid[m]) begin
                seen = 1'b1;
                rd   = m_rdata[m];
                err  = m_error[m];
            end
            touched = touched | (|slave_busy);
            k++;
            @(negedge in_clk);
        end
        if (rw) begin
            assert (seen) else abort_run("read finished without m_dvalid");
        end else begin
            model[model_key(addr)] = wd;
        end
        // grant released one cycle after req drops
        @(negedge in_clk);
        assert (!utilization && requests == '0)
            else abort_run("bus still granted after all masters went idle");
    endtask

    task automatic check_read(input string test, input addr_t addr, input data_t rd,
                              input logic err);
        assert (err == 1'b0) else report_mismatch(test, 0, err);
        assert (rd == model_read(addr)) else report_mismatch(test, model_read(addr), rd);
    endtask

    initial begin
        data_t                  rd;
        data_t                  wd;
        logic                   err;
        logic                   touched;
        addr_t                  addr;
        data_t                  prio_data [NUM_MASTERS];
        int                     order [$];
        logic [NUM_MASTERS-1:0] prev;

        void'($urandom(32'he835bc9d));
        in_clk    = 1'b0;
        rst       = 1'b1;
        m_execute = '0;
        m_rw      = '0;
        m_address = '0;
        m_wdata   = '0;
        repeat (4) @(posedge in_clk);
        rst <= 1'b0;
        @(negedge in_clk);
        assert (m_busy == '0 && m_dvalid == '0 && m_error == '0 && requests == '0
                && !utilization && slave_busy == '0 && !bus)
            else abort_run("outputs not zero after reset");

        // every master against every slave
        for (int m = 0; m < NUM_MASTERS; m++) begin
            for (int s = 0; s < NUM_SLAVES; s++) begin
                addr = make_addr(FIRST_SLAVE_ID + s, $urandom % 4096);
                wd   = data_t'($urandom);
                run_op(m, 1'b0, addr, wd, rd, err, touched);
                run_op(m, 1'b1, addr, '0, rd, err, touched);
                check_read("write_readback", addr, rd, err);
            end
        end

        // same-cycle writes to slave 2, index 0 must win first
        @(posedge in_clk);
        for (int m = 0; m < NUM_MASTERS; m++) begin
            prio_data[m] = data_t'($urandom);
            m_rw[m]      <= 1'b0;
            m_address[m] <= make_addr(2, m + 5);
            m_wdata[m]   <= prio_data[m];
            m_execute[m] <= 1'b1;
        end
        @(posedge in_clk);
        m_execute <= '0;
        prev = '1;
        while (order.size() < NUM_MASTERS) begin
            @(negedge in_clk);
            for (int m = 0; m < NUM_MASTERS; m++) begin
                if (prev[m] && !m_busy[m]) begin
                    order.push_back(m);
                end
            end
            prev = m_busy;
        end
        for (int m = 0; m < NUM_MASTERS; m++) begin
            assert (order[m] == m) else report_mismatch("priority_order", m, order[m]);
            model[model_key(make_addr(2, m + 5))] = prio_data[m];
        end
        for (int m = 0; m < NUM_MASTERS; m++) begin
            run_op(m, 1'b1, make_addr(2, m + 5), '0, rd, err, touched);
            check_read("priority_readback", make_addr(2, m + 5), rd, err);
        end

        // ids with no slave behind them
        for (int i = 0; i < 2; i++) begin
            addr = make_addr((i == 0) ? 0 : 6, $urandom % 4096);
            run_op(1, 1'b1, addr, '0, rd, err, touched);
            assert (err == 1'b1) else report_mismatch("unmapped_error", 1, err);
            assert (!touched) else abort_run("a slave answered an unmapped id");
        end

        // offset 19 aliases offset 3, slave 1 keeps its own word
        wd = data_t'($urandom);
        run_op(2, 1'b0, make_addr(3, 3), wd, rd, err, touched);
        run_op(2, 1'b1, make_addr(3, 19), '0, rd, err, touched);
        assert (err == 1'b0) else report_mismatch("offset_alias", 0, err);
        assert (rd == wd) else report_mismatch("offset_alias", wd, rd);
        run_op(2, 1'b1, make_addr(1, 3), '0, rd, err, touched);
        check_read("slave_isolation", make_addr(1, 3), rd, err);

        // second execute mid-write, different operands
        wd   = data_t'($urandom);
        addr = make_addr(1, 9);
        fork
            run_op(0, 1'b0, addr, wd, rd, err, touched);
            begin
                repeat (6) @(posedge in_clk);
                m_address[0] <= make_addr(1, 10);
                m_wdata[0]   <= ~wd;
                m_execute[0] <= 1'b1;
                @(posedge in_clk);
                m_execute[0] <= 1'b0;
            end
        join
        repeat (3) @(negedge in_clk);
        assert (!m_busy[0]) else abort_run("execute during m_busy started a transaction");
        run_op(0, 1'b1, addr, '0, rd, err, touched);
        check_read("ignored_execute", addr, rd, err);
        run_op(0, 1'b1, make_addr(1, 10), '0, rd, err, touched);
        check_read("ignored_execute", make_addr(1, 10), rd, err);

        if (dut0.props0.check_failed) begin
            abort_run("a bus property assertion failed");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
src/bus_cfg_pkg.sv
src/bus_frame_pkg.sv
src/master_link_if.sv
src/slave_link_if.sv
src/serial_tx.sv
src/serial_rx.sv
src/bus_arbiter.sv
src/bus_master.sv
src/memory_slave.sv
src/bus_top.sv
tb/bus_top_props.sv
tb/bus_top_tb.sv
